//--- bench/vtl_chip_assertions.sv
// slot rules for the sdram write strobe and cpu enable
// bound into cpu_bus_slots
module vtl_chip_assertions (
	input logic F14M,
	input logic RESET,
	input logic sdram_wr,
	input logic CPUENA
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [2:0] clk_phase; // clocks since reset mod 8

	// lines are 952 clocks, so the phase stays equal to hcnt mod 8
	always_ff @(posedge F14M) begin
		if (RESET) begin
			clk_phase <= '0;
		end else begin
			clk_phase <= clk_phase + 1'b1;
		end
	end

	// strobe comes up on the edge that ends slot 3
	wr_rise_after_slot3: assert property (@(posedge F14M) disable iff (RESET)
		$rose(sdram_wr) |-> $past(clk_phase) == 3'd3)
		else $error("sdram_wr rose outside the slot 3 edge");

	// two clock write, slots 4 and 5 only
	wr_inside_cpu_slots: assert property (@(posedge F14M) disable iff (RESET)
		sdram_wr |-> (clk_phase == 3'd4 || clk_phase == 3'd5))
		else $error("sdram_wr high in slot %0d", clk_phase);

	cpuena_slot2_only: assert property (@(posedge F14M) disable iff (RESET)
		CPUENA |-> clk_phase == 3'd2)
		else $error("CPUENA high in slot %0d", clk_phase);

endmodule

bind cpu_bus_slots vtl_chip_assertions slot_rules_i (
	.F14M     (F14M),
	.RESET    (RESET),
	.sdram_wr (sdram_wr),
	.CPUENA   (CPUENA)
);

//--- bench/vtl_chip_tb.sv
// testbench for the video chip: clock, reset, sdram model
// stimulus table with cpu cycles, sync, border and pixel checks
module vtl_chip_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import vtl_pkg::*;

	localparam int LINE_CLKS  = 952;
	localparam int FRAME_CLKS = 952 * 312;
	localparam int SEL_HSYNC  = 0;
	localparam int SEL_VSYNC  = 1;
	localparam int SEL_CPUENA = 2;
	localparam byte_t FG_ONLY = 8'hf0; // pixel row codes, else run length
	localparam byte_t BG_ONLY = 8'h0b;

	typedef enum logic [2:0] {OP_SYNC, OP_IO_WR, OP_MEM_WR, OP_MEM_RD, OP_BORDER, OP_PIXELS} op_t;
	typedef struct packed {
		op_t        op;
		cpu_addr_t  addr;    // port or cpu address window
		byte_t      data;    // DO, or pattern for pixel rows
		byte_t      exp_val; // write pulses, or pixel code
	} row_t;

	localparam int N_ROWS = 24;
	localparam row_t ROWS [N_ROWS] = '{
		'{OP_SYNC,   16'h0000, 8'h00, 8'h00},
		'{OP_IO_WR,  16'h0041, 8'h05, 8'h00}, // window 1 -> bank 5
		'{OP_MEM_WR, 16'h4000, 8'ha5, 8'h01},
		'{OP_IO_WR,  16'h0042, 8'h01, 8'h00}, // window 2 -> rom bank 1
		'{OP_MEM_WR, 16'h8000, 8'h3c, 8'h00},
		'{OP_IO_WR,  16'h0043, 8'h07, 8'h00},
		'{OP_MEM_WR, 16'hc000, 8'h96, 8'h01},
		'{OP_IO_WR,  16'h0040, 8'h02, 8'h00}, // window 0 -> mapped io
		'{OP_MEM_RD, 16'h4000, 8'h00, 8'h00},
		'{OP_MEM_RD, 16'h0000, 8'h00, 8'h00},
		'{OP_MEM_RD, 16'h8000, 8'h00, 8'h00},
		'{OP_IO_WR,  16'h0044, 8'h50, 8'h00}, // border 5, gr 5, page 7
		'{OP_BORDER, 16'h0000, 8'h00, 8'h00},
		'{OP_IO_WR,  16'h0045, 8'he1, 8'h00}, // fg 14, bg 1
		'{OP_MEM_WR, 16'h0000, 8'h08, 8'h00}, // graphics on
		'{OP_PIXELS, 16'h0000, 8'hff, FG_ONLY},
		'{OP_PIXELS, 16'h0000, 8'h00, BG_ONLY},
		'{OP_PIXELS, 16'h0000, 8'h55, 8'h01},
		'{OP_IO_WR,  16'h0044, 8'h96, 8'h00}, // border 9, gr 2
		'{OP_PIXELS, 16'h0000, 8'h55, 8'h02},
		'{OP_PIXELS, 16'h0000, 8'hff, FG_ONLY},
		'{OP_MEM_WR, 16'h0000, 8'h00, 8'h00}, // graphics off
		'{OP_PIXELS, 16'h0000, 8'hff, BG_ONLY},
		'{OP_BORDER, 16'h0000, 8'h00, 8'h00}
	};

	logic        F14M;
	logic        RESET;
	logic        MREQ_n;
	logic        IORQ_n;
	logic        RD_n;
	logic        WR_n;
	cpu_addr_t   A;
	byte_t       DO;
	byte_t       DI;
	logic        CPUENA;
	sdram_addr_t sdram_addr;
	byte_t       sdram_dout = 8'h00;
	byte_t       sdram_din;
	logic        sdram_wr;
	logic        sdram_rd;
	logic        hsync;
	logic        vsync;
	chan_t       r;
	chan_t       g;
	chan_t       b;

	byte_t       pattern = 8'h00;   // page 7 contents
	int          wr_count = 0;      // sdram_wr pulses seen
	logic        wr_last = 1'b0;
	sdram_addr_t wr_addr;
	byte_t       wr_data;
	bank_t       bank_model [4] = '{default: 4'd0};
	color_t      border_model = 4'd10;
	color_t      fg_model = 4'd12;
	color_t      bg_model = 4'd3;
	int          seed = 37;
	int          tests = 0;
	int          errors = 0;
	event        abort_run;

	vtl_chip dut_i (.*);

	initial begin
		F14M = 1'b0;
		forever #10 F14M = ~F14M;
	end

	function automatic byte_t model_value(input sdram_addr_t ad);
		if (ad[24:14] == 11'd7) begin
			return pattern;
		end
		return ad[7:0] ^ 8'h5a;
	endfunction

	// registered read data, one clock behind the address
	always @(posedge F14M) begin
		sdram_dout <= model_value(sdram_addr);
	end

	always @(negedge F14M) begin
		if (sdram_wr && !wr_last) begin
			wr_count <= wr_count + 1;
			wr_addr  <= sdram_addr;
			wr_data  <= sdram_din;
		end
		wr_last <= sdram_wr;
	end

	function automatic logic [17:0] palette_rgb(input color_t c);
		logic [11:0] e;
		e = PALETTE[c];
		return {e[11:8], 2'b00, e[7:4], 2'b00, e[3:0], 2'b00}; // top nibble then two zeros
	endfunction

	function automatic logic level_of(input int sel);
		case (sel)
			SEL_HSYNC: return hsync;
			SEL_VSYNC: return vsync;
			default:   return CPUENA;
		endcase
	endfunction

	task automatic wait_level(input int sel, input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (level_of(sel) != level) begin
			if (n == limit) begin
				$display("timeout waiting for %s after %0d clocks", what, limit);
				-> abort_run;
				forever @(negedge F14M); // run ends from the abort process
			end
			@(negedge F14M);
			n++;
		end
	endtask

	task automatic frame_start();
		wait_level(SEL_VSYNC, 1'b0, FRAME_CLKS + 16, "vsync low");
		wait_level(SEL_VSYNC, 1'b1, 3 * LINE_CLKS, "vsync high"); // now at line 2
	endtask

	// one cpu cycle held over slots 3 to 5
	task automatic cpu_cycle(input logic io, input logic write, input cpu_addr_t addr,
			input byte_t data);
		wait_level(SEL_CPUENA, 1'b1, 16, "CPUENA");
		@(posedge F14M);
		MREQ_n <= io;
		IORQ_n <= !io;
		RD_n   <= write;
		WR_n   <= !write;
		A      <= addr;
		DO     <= data;
		repeat (3) @(posedge F14M);
		MREQ_n <= 1'b1;
		IORQ_n <= 1'b1;
		RD_n   <= 1'b1;
		WR_n   <= 1'b1;
		@(negedge F14M); // DI and write record settled
	endtask

	task automatic io_write(input byte_t port, input byte_t data);
		cpu_cycle(1'b1, 1'b1, {8'h00, port}, data);
		if (port[7:2] == 6'h10) begin
			bank_model[port[1:0]] = data[3:0];
		end else if (port == 8'h44) begin
			border_model = data[7:4];
		end else if (port == 8'h45) begin
			fg_model = data[7:4];
			bg_model = data[3:0];
		end
	endtask

	task automatic sync_counts(output logic ok);
		int h_low;
		int v_low;
		int rd_low;
		h_low = 0;
		v_low = 0;
		rd_low = 0;
		ok = 1'b1;
		frame_start();
		repeat (FRAME_CLKS) begin
			@(negedge F14M);
			h_low += int'(!hsync);
			v_low += int'(!vsync);
			rd_low += int'(!sdram_rd); // reads stay on after reset
		end
		if (h_low != 66 * 312) begin
			$display("Error: hsync low clocks got %h expected %h", h_low, 66 * 312);
			ok = 1'b0;
		end
		if (v_low != 2 * LINE_CLKS) begin
			$display("Error: vsync low clocks got %h expected %h", v_low, 2 * LINE_CLKS);
			ok = 1'b0;
		end
		if (rd_low != 0) begin
			$display("Error: sdram_rd low clocks got %h expected %h", rd_low, 0);
			ok = 1'b0;
		end
	endtask

	task automatic write_pulse(input cpu_addr_t base, input byte_t data, input byte_t pulses,
			output logic ok);
		cpu_addr_t   a;
		sdram_addr_t exp_addr;
		int          start;
		a = {base[15:14], 14'($random(seed))};
		exp_addr = {7'd0, bank_model[a[15:14]], a[13:0]};
		start = wr_count;
		ok = 1'b1;
		cpu_cycle(1'b0, 1'b1, a, data);
		if (wr_count - start != int'(pulses)) begin
			$display("Error: sdram_wr pulses got %h expected %h", wr_count - start, pulses);
			ok = 1'b0;
		end else if (pulses != 8'd0) begin
			if (wr_addr != exp_addr) begin
				$display("Error: sdram_addr got %h expected %h", wr_addr, exp_addr);
				ok = 1'b0;
			end
			if (wr_data != data) begin
				$display("Error: sdram_din got %h expected %h", wr_data, data);
				ok = 1'b0;
			end
		end
	endtask

	task automatic read_data(input cpu_addr_t base, output logic ok);
		cpu_addr_t a;
		bank_t     bank;
		byte_t     exp_di;
		a = {base[15:14], 14'($random(seed))};
		bank = bank_model[a[15:14]];
		exp_di = (bank == 4'd2) ? 8'hff : model_value({7'd0, bank, a[13:0]});
		ok = 1'b1;
		cpu_cycle(1'b0, 1'b0, a, 8'h00);
		if (DI !== exp_di) begin
			$display("Error: DI got %h expected %h", DI, exp_di);
			ok = 1'b0;
		end
	endtask

	task automatic border_colour(output logic ok);
		logic [17:0] px;
		ok = 1'b1;
		frame_start();
		wait_level(SEL_HSYNC, 1'b1, LINE_CLKS + 16, "hsync high");
		repeat (110) @(negedge F14M); // hcnt near 176, left border
		px = {r, g, b};
		if (px != palette_rgb(border_model)) begin
			$display("Error: rgb in border got %h expected %h", px, palette_rgb(border_model));
			ok = 1'b0;
		end
		wait_level(SEL_HSYNC, 1'b0, LINE_CLKS + 16, "hsync low");
		repeat (30) @(negedge F14M); // inside horizontal blank
		px = {r, g, b};
		if (px != 18'h0) begin
			$display("Error: rgb in blank got %h expected %h", px, 18'h0);
			ok = 1'b0;
		end
	endtask

	task automatic pixel_runs(input byte_t pat, input byte_t exp_val, output logic ok);
		logic [17:0] fg_rgb;
		logic [17:0] bg_rgb;
		logic [17:0] px;
		logic [95:0] s;  // 1 where fg shows
		int          run;
		fg_rgb = palette_rgb(fg_model);
		bg_rgb = palette_rgb(bg_model);
		ok = 1'b1;
		pattern = pat;
		frame_start();
		repeat (120) begin
			wait_level(SEL_HSYNC, 1'b0, LINE_CLKS + 16, "hsync low");
			wait_level(SEL_HSYNC, 1'b1, LINE_CLKS + 16, "hsync high");
		end
		repeat (250) @(negedge F14M); // middle of an active line
		for (int i = 0; i < 96; i++) begin
			@(negedge F14M);
			px = {r, g, b};
			s[i] = (px == fg_rgb);
			if (ok && px != fg_rgb && px != bg_rgb) begin
				$display("Error: rgb got %h expected %h or %h", px, fg_rgb, bg_rgb);
				ok = 1'b0;
			end
		end
		if (exp_val == FG_ONLY) begin
			if (s != '1) begin
				$display("active area shows more than the foreground colour");
				ok = 1'b0;
			end
		end else if (exp_val == BG_ONLY) begin
			if (s != '0) begin
				$display("active area shows more than the background colour");
				ok = 1'b0;
			end
		end else begin
			run = int'(exp_val);
			for (int i = run; i < 96; i++) begin
				if (ok && s[i] == s[i - run]) begin
					$display("pixels do not alternate in runs of %0d", run);
					ok = 1'b0;
				end
			end
		end
	endtask

	initial begin
		@(abort_run);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		logic ok;
		op_t  op;
		RESET  = 1'b1;
		MREQ_n = 1'b1;
		IORQ_n = 1'b1;
		RD_n   = 1'b1;
		WR_n   = 1'b1;
		A      = '0;
		DO     = '0;
		repeat (4) @(posedge F14M);
		RESET <= 1'b0;
		@(negedge F14M);
		for (int i = 0; i < N_ROWS; i++) begin
			op = ROWS[i].op;
			ok = 1'b1;
			case (op)
				OP_SYNC:   sync_counts(ok);
				OP_IO_WR:  io_write(ROWS[i].addr[7:0], ROWS[i].data);
				OP_MEM_WR: write_pulse(ROWS[i].addr, ROWS[i].data, ROWS[i].exp_val, ok);
				OP_MEM_RD: read_data(ROWS[i].addr, ok);
				OP_BORDER: border_colour(ok);
				default:   pixel_runs(ROWS[i].data, ROWS[i].exp_val, ok);
			endcase
			if (op != OP_IO_WR) begin // port writes are setup only
				tests++;
				errors += int'(!ok);
				$display("row %0d %s: %s", i, op.name(), ok ? "pass" : "fail");
			end
		end
		$display("tests run %0d, tests failed %0d", tests, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -f sim.log \
	&& verilator --binary --timing --assert -j 0 --top-module vtl_chip_tb \
		-f vtl_chip.f -o vtl_chip_sim > build.log 2>&1 \
	&& ./obj_dir/vtl_chip_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- source/cpu_bus_slots.sv
// bank registers, port and mapped io decode, video registers
// sdram strobes, cpu read latch and the slot address mux
module cpu_bus_slots (
	input  logic                 F14M,
	input  logic                 RESET,
	input  logic                 MREQ_n,
	input  logic                 IORQ_n,
	input  logic                 RD_n,
	input  logic                 WR_n,
	input  vtl_pkg::cpu_addr_t   A,
	input  vtl_pkg::byte_t       DO,
	output vtl_pkg::byte_t       DI,
	output logic                 CPUENA,
	output vtl_pkg::sdram_addr_t sdram_addr,
	input  vtl_pkg::byte_t       sdram_dout,
	output vtl_pkg::byte_t       sdram_din,
	output logic                 sdram_wr,
	output logic                 sdram_rd,
	input  vtl_pkg::vram_addr_t  vram_addr,
	raster_if.rd                 raster,
	video_cfg_if.drv             cfg
);
	import vtl_pkg::*;

	logic        mreq;
	logic        iorq;
	logic        rd;
	logic        wr;
	bank_t       banks [4];   // one per 16K cpu window
	bank_t       bank;
	logic        bank_is_ram;
	logic        mapped_io;
	logic        cpu_slot;
	logic        video_slot;
	logic        cpu_io_wr;
	sdram_addr_t video_addr;
	sdram_addr_t cpu_addr;

	assign mreq = ~MREQ_n;
	assign iorq = ~IORQ_n;
	assign rd   = ~RD_n;
	assign wr   = ~WR_n;

	assign bank        = banks[A[15:14]];
	assign bank_is_ram = (bank >= RAM_BANK_LO) && (bank <= RAM_BANK_HI);
	assign mapped_io   = (bank == BANK_MAPPED_IO);

	assign CPUENA     = (raster.slot == SLOT_CPUENA);
	assign cpu_slot   = (raster.slot >= SLOT_CPU_START) && (raster.slot <= SLOT_CPU_END);
	assign video_slot = (raster.slot == 3'd7) || (raster.slot < 3'd2); // slots 7 0 1
	assign cpu_io_wr  = (raster.slot == SLOT_CPU_START) && iorq && wr;

	// page sits above the 14 bit video offset
	assign video_addr = {7'd0, cfg.page7 ? 4'd7 : 4'd3, vram_addr};
	assign cpu_addr   = {7'd0, bank, A[13:0]};
	assign sdram_addr = video_slot ? video_addr : cpu_slot ? cpu_addr : '0;

	always_ff @(posedge F14M) begin
		if (RESET) begin
			banks          <= '{default: '0};
			sdram_wr       <= 1'b0;
			sdram_rd       <= 1'b0;
			cfg.gfx_enable <= 1'b0;
			cfg.mode       <= GR_5;
			cfg.page7      <= 1'b1;
			cfg.border     <= 4'd10;
			cfg.fg         <= 4'd12;
			cfg.bg         <= 4'd3;
		end else begin
			sdram_rd <= 1'b1; // always reading
			if (raster.slot == SLOT_CPU_START && mreq) begin
				sdram_wr <= wr && bank_is_ram; // rom and io banks stay untouched
				if (wr && mapped_io) begin
					cfg.gfx_enable <= DO[3];
				end
			end
			if (raster.slot == SLOT_CPU_END) begin
				sdram_wr <= 1'b0; // end of the two clock write
			end
			if (cpu_io_wr) begin
				if (A[7:2] == PORT_BANK0[7:2]) begin
					banks[A[1:0]] <= DO[3:0];
				end else if (A[7:0] == PORT_VIDEO) begin
					cfg.page7  <= ~DO[3];
					cfg.border <= DO[7:4];
					cfg.mode   <= (DO[2:0] == 3'b110) ? GR_2 : GR_5;
				end else if (A[7:0] == PORT_COLORS) begin
					cfg.fg <= DO[7:4];
					cfg.bg <= DO[3:0];
				end
			end
		end
	end

	// write data and cpu read latch
	always_ff @(posedge F14M) begin
		if (raster.slot == SLOT_CPU_START && mreq) begin
			sdram_din <= DO;
		end
		if (raster.slot == SLOT_CPU_END && mreq && rd) begin
			DI <= mapped_io ? 8'hFF : sdram_dout; // no keyboard behind mapped io
		end
	end

endmodule

//--- source/pixel_shifter.sv
// graphic shift register, pixel rate per mode,
// area colour choice and palette lookup
module pixel_shifter (
	input  logic           F14M,
	input  logic           RESET,
	raster_if.rd           raster,
	video_cfg_if.rd        cfg,
	input  vtl_pkg::byte_t vram_data,
	output vtl_pkg::chan_t r,
	output vtl_pkg::chan_t g,
	output vtl_pkg::chan_t b
);
	import vtl_pkg::*;

	byte_t       shreg;  // lsb is the next pixel
	color_t      pixel;
	logic        tick;   // new pixel this clock
	logic        load;
	logic        shift;
	logic [11:0] rgb;

	assign tick  = (cfg.mode == GR_5) || !raster.xcnt[0]; // gr 2 doubles each bit
	assign load  = (cfg.mode == GR_5) ? (raster.xcnt[2:0] == 3'h7) : (raster.xcnt[3:0] == 4'hf);
	assign shift = raster.in_active && cfg.gfx_enable && tick;

	always_ff @(posedge F14M) begin
		if (RESET) begin
			pixel <= '0;
		end else if (raster.in_blank) begin
			pixel <= '0;
		end else if (raster.in_border) begin
			pixel <= cfg.border;
		end else if (!cfg.gfx_enable) begin
			pixel <= cfg.bg;   // graphics off
		end else if (tick) begin
			pixel <= shreg[0] ? cfg.fg : cfg.bg;
		end
	end

	// load overrides the last shift of a byte
	always_ff @(posedge F14M) begin
		if (load) begin
			shreg <= vram_data;
		end else if (shift) begin
			shreg <= shreg >> 1;
		end
	end

	assign rgb = PALETTE[pixel];
	assign r   = {rgb[11:8], 2'b00};
	assign g   = {rgb[7:4], 2'b00};
	assign b   = {rgb[3:0], 2'b00};

endmodule

//--- source/raster_timing.sv
// raster counters, negative syncs, bus slot
// area flags and the row start strobe
module raster_timing #(
	parameter int LEFT_BORDER = vtl_pkg::LEFT_BORDER
) (
	input  logic  F14M,
	input  logic  RESET,
	output logic  hsync,
	output logic  vsync,
	raster_if.drv raster
);
	import vtl_pkg::*;

	localparam int H_START = H_SYNC + H_BACK + LEFT_BORDER; // first active column

	localparam raster_cnt_t H_LAST   = raster_cnt_t'(H_SYNC + H_BACK + H_VISIBLE + H_FRONT - 1);
	localparam raster_cnt_t V_LAST   = raster_cnt_t'(V_TOTAL - 1);
	localparam raster_cnt_t X0       = raster_cnt_t'(H_START);
	localparam raster_cnt_t X1       = raster_cnt_t'(H_START + ACTIVE_W);
	localparam raster_cnt_t VIS_L    = raster_cnt_t'(H_SYNC + H_BACK);
	localparam raster_cnt_t VIS_R    = raster_cnt_t'(H_SYNC + H_BACK + H_VISIBLE);
	localparam raster_cnt_t Y0       = raster_cnt_t'(TOP_BORDER);
	localparam raster_cnt_t Y1       = raster_cnt_t'(TOP_BORDER + ACTIVE_H);
	localparam raster_cnt_t ROW_LOAD = raster_cnt_t'(H_START - 9); // one byte ahead plus one

	raster_cnt_t hcnt;
	raster_cnt_t vcnt;
	raster_cnt_t ycnt;
	logic        h_act;
	logic        v_act;
	logic        blank;

	always_ff @(posedge F14M) begin
		if (RESET) begin
			hcnt <= '0;
			vcnt <= '0;
			ycnt <= '0;
		end else if (hcnt == H_LAST) begin
			hcnt <= '0;
			vcnt <= (vcnt == V_LAST) ? '0 : vcnt + 1'b1;
			if (vcnt == Y0 - 1'b1) begin
				ycnt <= '0; // first active line is next
			end else begin
				ycnt <= ycnt + 1'b1;
			end
		end else begin
			hcnt <= hcnt + 1'b1;
		end
	end

	assign hsync = (hcnt >= raster_cnt_t'(H_SYNC));
	assign vsync = (vcnt >= raster_cnt_t'(V_SYNC));

	assign h_act = (hcnt >= X0) && (hcnt < X1);
	assign v_act = (vcnt >= Y0) && (vcnt < Y1);
	assign blank = (hcnt < VIS_L) || (hcnt >= VIS_R) || (vcnt < raster_cnt_t'(V_SYNC));

	assign raster.slot      = hcnt[2:0];
	assign raster.xcnt      = hcnt - X0;
	assign raster.ycnt      = ycnt;
	assign raster.row_start = (hcnt == ROW_LOAD); // slot 7 with default border
	assign raster.in_blank  = blank;
	assign raster.in_active = !blank && h_act && v_act;
	assign raster.in_border = !blank && !(h_act && v_act);

endmodule

//--- source/video_fetch.sv
// video ram row address, per byte address step
// and the fetched data latch
module video_fetch #(
	parameter int LEFT_BORDER = vtl_pkg::LEFT_BORDER
) (
	input  logic                F14M,
	input  logic                RESET,
	raster_if.rd                raster,
	video_cfg_if.rd             cfg,
	input  vtl_pkg::byte_t      sdram_dout,
	output vtl_pkg::vram_addr_t vram_addr,
	output vtl_pkg::byte_t      vram_data
);
	import vtl_pkg::*;

	// xcnt value where the left border begins
	localparam raster_cnt_t X_LEFT = raster_cnt_t'(2 ** $bits(raster_cnt_t) - LEFT_BORDER);

	raster_cnt_t y;
	logic        fetch_win; // left border and active area
	logic        step;
	vram_addr_t  row_gr5;
	vram_addr_t  row_gr2;

	assign y         = raster.ycnt;
	assign fetch_win = (raster.xcnt < raster_cnt_t'(ACTIVE_W)) || (raster.xcnt >= X_LEFT);

	// gr 2 uses each byte for 16 clocks
	assign step = (cfg.mode == GR_2) ? (raster.xcnt[3:0] == 4'hf) : (raster.xcnt[2:0] == 3'h7);

	// scrambled row layouts
	assign row_gr5 = {y[2], y[1], y[0], y[5], y[4], y[3], y[7], y[6], y[7], y[6], 4'h0};
	assign row_gr2 = {1'b1, y[2], y[1], y[5], y[4], y[3], y[0], y[7], y[6], y[7], y[6], 3'h0};

	always_ff @(posedge F14M) begin
		if (RESET) begin
			vram_addr <= '0;
		end else if (raster.row_start) begin
			vram_addr <= (cfg.mode == GR_2) ? row_gr2 : row_gr5;
		end else if (fetch_win && step) begin
			vram_addr <= vram_addr + 1'b1; // next byte of the row
		end
	end

	always_ff @(posedge F14M) begin
		if (raster.xcnt[2:0] == 3'h0) begin
			vram_data <= sdram_dout; // end of video slot 0
		end
	end

endmodule

//--- source/vtl_chip.sv
// video chip top with raster timing, cpu bus slots,
// video fetch and pixel shifter
module vtl_chip #(
	parameter int LEFT_BORDER = vtl_pkg::LEFT_BORDER
) (
	input  logic                 F14M,
	input  logic                 RESET,
	input  logic                 MREQ_n,
	input  logic                 IORQ_n,
	input  logic                 RD_n,
	input  logic                 WR_n,
	input  vtl_pkg::cpu_addr_t   A,
	input  vtl_pkg::byte_t       DO,
	output vtl_pkg::byte_t       DI,
	output logic                 CPUENA,     // cpu clock enable
	output vtl_pkg::sdram_addr_t sdram_addr,
	input  vtl_pkg::byte_t       sdram_dout,
	output vtl_pkg::byte_t       sdram_din,
	output logic                 sdram_wr,
	output logic                 sdram_rd,
	output logic                 hsync,
	output logic                 vsync,
	output vtl_pkg::chan_t       r,
	output vtl_pkg::chan_t       g,
	output vtl_pkg::chan_t       b
);
	import vtl_pkg::*;

	vram_addr_t vram_addr;
	byte_t      vram_data;

	raster_if    raster ();
	video_cfg_if cfg ();

	raster_timing #(.LEFT_BORDER(LEFT_BORDER)) raster_timing_i (
		.F14M   (F14M),
		.RESET  (RESET),
		.hsync  (hsync),
		.vsync  (vsync),
		.raster (raster.drv)
	);

	cpu_bus_slots cpu_bus_slots_i (
		.F14M       (F14M),
		.RESET      (RESET),
		.MREQ_n     (MREQ_n),
		.IORQ_n     (IORQ_n),
		.RD_n       (RD_n),
		.WR_n       (WR_n),
		.A          (A),
		.DO         (DO),
		.DI         (DI),
		.CPUENA     (CPUENA),
		.sdram_addr (sdram_addr),
		.sdram_dout (sdram_dout),
		.sdram_din  (sdram_din),
		.sdram_wr   (sdram_wr),
		.sdram_rd   (sdram_rd),
		.vram_addr  (vram_addr),
		.raster     (raster.rd),
		.cfg        (cfg.drv)
	);

	video_fetch #(.LEFT_BORDER(LEFT_BORDER)) video_fetch_i (
		.F14M       (F14M),
		.RESET      (RESET),
		.raster     (raster.rd),
		.cfg        (cfg.rd),
		.sdram_dout (sdram_dout),
		.vram_addr  (vram_addr),
		.vram_data  (vram_data)
	);

	pixel_shifter pixel_shifter_i (
		.F14M      (F14M),
		.RESET     (RESET),
		.raster    (raster.rd),
		.cfg       (cfg.rd),
		.vram_data (vram_data),
		.r         (r),
		.g         (g),
		.b         (b)
	);

endmodule

//--- source/vtl_if.sv
// raster_if with raster position, bus slot and area flags
// video_cfg_if with the video register state
interface raster_if;
	import vtl_pkg::*;

	slot_t       slot;      // hcnt mod 8
	raster_cnt_t xcnt;      // x inside active area, wraps below zero
	raster_cnt_t ycnt;      // line inside active area
	logic        row_start; // load row address
	logic        in_blank;
	logic        in_border;
	logic        in_active;

	modport drv (output slot, xcnt, ycnt, row_start, in_blank, in_border, in_active);
	modport rd (input slot, xcnt, ycnt, row_start, in_blank, in_border, in_active);
endinterface

interface video_cfg_if;
	import vtl_pkg::*;

	logic     gfx_enable; // bit 3 of mapped io
	gr_mode_t mode;
	logic     page7;      // video ram in page 7, else page 3
	color_t   border;
	color_t   fg;
	color_t   bg;

	modport drv (output gfx_enable, mode, page7, border, fg, bg);
	modport rd (input gfx_enable, mode, page7, border, fg, bg);
endinterface

//--- source/vtl_pkg.sv
// shared widths, typedefs and mode enum for the video chip
// raster and slot constants, port numbers and the colour palette
package vtl_pkg;

	typedef logic [15:0] cpu_addr_t;   // z80 address bus
	typedef logic [7:0]  byte_t;
	typedef logic [24:0] sdram_addr_t;
	typedef logic [13:0] vram_addr_t;  // offset inside the 16K video page
	typedef logic [3:0]  bank_t;       // 16K bank number
	typedef logic [3:0]  color_t;      // palette index
	typedef logic [5:0]  chan_t;       // one colour channel out

	typedef logic [9:0]  raster_cnt_t; // hcnt, vcnt, ycnt
	typedef logic [2:0]  slot_t;       // bus slot within 8 clocks

	typedef enum logic {GR_5, GR_2} gr_mode_t;

	// horizontal timing in F14M clocks, 952 per line
	localparam int H_SYNC      = 66;
	localparam int H_BACK      = 78;
	localparam int H_FRONT     = 10;
	localparam int H_VISIBLE   = 798;
	localparam int LEFT_BORDER = 72;
	localparam int ACTIVE_W    = 640;
	// vertical timing in lines
	localparam int V_TOTAL     = 312;
	localparam int V_SYNC      = 2;
	localparam int TOP_BORDER  = 64;
	localparam int ACTIVE_H    = 192;

	localparam slot_t SLOT_CPU_START = 3'd3; // cpu owns the bus in 3..5
	localparam slot_t SLOT_CPU_END   = 3'd5;
	localparam slot_t SLOT_CPUENA    = 3'd2;

	localparam byte_t PORT_BANK0     = 8'h40; // banks at 0x40..0x43
	localparam byte_t PORT_VIDEO     = 8'h44;
	localparam byte_t PORT_COLORS    = 8'h45;
	localparam bank_t BANK_MAPPED_IO = 4'd2;
	localparam bank_t RAM_BANK_LO    = 4'd4;  // writable ram banks
	localparam bank_t RAM_BANK_HI    = 4'd7;

	// 12 bit rgb, 4 bits each
	localparam logic [11:0] PALETTE [16] = '{
		12'h000, 12'h00f, 12'h080, 12'h09f, // black blue green cyan
		12'h600, 12'h83f, 12'h780, 12'hccc, // red magenta yellow grey
		12'h667, 12'h88f, 12'h5e3, 12'h8cf, // bright versions
		12'hf59, 12'hf9f, 12'hee6, 12'hfff
	};

endpackage

//--- vtl_chip.f
source/vtl_pkg.sv
source/vtl_if.sv
source/raster_timing.sv
source/cpu_bus_slots.sv
source/video_fetch.sv
source/pixel_shifter.sv
source/vtl_chip.sv
bench/vtl_chip_assertions.sv
bench/vtl_chip_tb.sv
